/* hw/mcu_consts.svh */
/*
 * MCU power and interrupt constants.
 * Domain counts and indices, sequencer timing and the interrupt vector layout.
 */
`ifndef MCU_CONSTS_SVH
`define MCU_CONSTS_SVH

// domain layout with banks at 2..5
`define NUM_BANKS    4
`define EXT_DOMAINS  2
`define NUM_DOMAINS  8
`define CPU_DOM      0
`define PERIPH_DOM   1
`define BANK0_DOM    2
`define EXT0_DOM     6

// sequencer timing in clock cycles
`define STEP_DELAY   2
`define ACK_TIMEOUT  64

// interrupt vector positions
`define IRQ_SW_POS     3
`define IRQ_TIMER0_POS 7
`define IRQ_EXT_POS    11
`define IRQ_FAST_LO    16
`define IRQ_FAST_HI    30

`endif

/* hw/pwr_pkg.sv */
/*
 * Power-domain types: commands, per-domain control bundle and sequencer enums.
 */
`default_nettype none

package pwr_pkg;

  typedef logic [2:0] domain_idx_t;

  typedef enum logic [1:0] {
    PWR_ON  = 2'd0,
    PWR_OFF = 2'd1,
    PWR_RET = 2'd2
  } pwr_op_e;

  typedef struct packed {
    domain_idx_t dom;
    pwr_op_e     op;
  } pwr_cmd_t;

  // active-low controls where all ones means fully powered
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic retentive_en_n;
    logic clkgate_en_n;
  } pwr_ctrl_t;

  // which control bit a single sequencer step writes
  typedef enum logic [2:0] {
    STEP_PWRGATE   = 3'd0,
    STEP_ISOGATE   = 3'd1,
    STEP_RST       = 3'd2,
    STEP_RETENTIVE = 3'd3,
    STEP_CLKGATE   = 3'd4
  } pwr_step_e;

  typedef enum logic [1:0] {
    SEQ_IDLE     = 2'd0,
    SEQ_STEP     = 2'd1,
    SEQ_SETTLE   = 2'd2,
    SEQ_ACK_WAIT = 2'd3
  } seq_state_e;

endpackage

`default_nettype wire

/* hw/irq_pkg.sv */
/*
 * Interrupt vector types and the grouping of the fast interrupt sources.
 */
`default_nettype none

package irq_pkg;

  typedef logic [31:0] irq_vec_t;
  typedef logic [14:0] fast_irq_t;
  typedef logic [3:0]  timer_irq_t;
  typedef logic [7:0]  gpio_irq_t;

  // msb first in fast group bit order
  typedef struct packed {
    logic      rsvd;
    gpio_irq_t gpio_ao;
    logic      spi_flash;
    logic      spi;
    logic      dma_done;
    logic [2:0] timer;
  } fast_src_t;

endpackage

`default_nettype wire

/* hw/pwr_step_timer.sv */
/*
 * Down-counter for the step settle delay and the switch ack timeout.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module pwr_step_timer (
  input  logic clk_i,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic mode_i,
  input  logic stop_i,
  output logic done_o,
  output logic expired_o
);

  localparam int cnt_w = $clog2(`ACK_TIMEOUT + 1);

  logic [cnt_w-1:0] cnt_q;
  logic             run_q;
  logic             mode_q;
  logic             last;

  assign last = run_q && (cnt_q == cnt_w'(1));

  // mode high selects the ack timeout
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cnt_q  <= '0;
      run_q  <= 1'b0;
      mode_q <= 1'b0;
    end else if (start_i) begin
      run_q  <= 1'b1;
      mode_q <= mode_i;
      cnt_q  <= mode_i ? cnt_w'(`ACK_TIMEOUT) : cnt_w'(`STEP_DELAY);
    end else if (stop_i || last) begin
      run_q <= 1'b0;
    end else if (run_q) begin
      cnt_q <= cnt_q - cnt_w'(1);
    end
  end

  assign done_o    = last & ~mode_q;
  assign expired_o = last & mode_q;

endmodule

`default_nettype wire

/* hw/pwr_domain_regs.sv */
/*
 * Per-domain power control registers with two-flop switch acknowledge
 * synchronizers. Debug ndmreset is merged into every domain reset.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module pwr_domain_regs
  import pwr_pkg::*;
(
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               step_we_i,
  input  domain_idx_t                        step_dom_i,
  input  pwr_step_e                          step_kind_i,
  input  logic                               step_val_i,
  input  logic                               ndmreset_ni,
  input  logic [`NUM_DOMAINS-1:0]            pwrgate_ack_ni,
  output logic [`NUM_DOMAINS-1:0]            ack_n_sync_o,
  output logic                               cpu_pwr_on_o,
  output pwr_ctrl_t [`NUM_DOMAINS-1:0]       pwr_ctrl_o
);

  pwr_ctrl_t [`NUM_DOMAINS-1:0] ctrl_q;
  logic [`NUM_DOMAINS-1:0]      ack_meta_q;
  logic [`NUM_DOMAINS-1:0]      ack_sync_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '1;
    end else if (step_we_i) begin
      case (step_kind_i)
        STEP_PWRGATE:   ctrl_q[step_dom_i].pwrgate_en_n   <= step_val_i;
        STEP_ISOGATE:   ctrl_q[step_dom_i].isogate_en_n   <= step_val_i;
        STEP_RST:       ctrl_q[step_dom_i].rst_n          <= step_val_i;
        STEP_RETENTIVE: ctrl_q[step_dom_i].retentive_en_n <= step_val_i;
        STEP_CLKGATE:   ctrl_q[step_dom_i].clkgate_en_n   <= step_val_i;
        default: ;
      endcase
    end
  end

  // switch cell acks are async to clk_i
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ack_meta_q <= '1;
      ack_sync_q <= '1;
    end else begin
      ack_meta_q <= pwrgate_ack_ni;
      ack_sync_q <= ack_meta_q;
    end
  end

  assign ack_n_sync_o = ack_sync_q;
  assign cpu_pwr_on_o = ctrl_q[`CPU_DOM].pwrgate_en_n;

  always_comb begin
    for (int i = 0; i < `NUM_DOMAINS; i++) begin
      pwr_ctrl_o[i]       = ctrl_q[i];
      pwr_ctrl_o[i].rst_n = ctrl_q[i].rst_n & ndmreset_ni;
    end
  end

endmodule

`default_nettype wire

/* hw/irq_vector_map.sv */
/*
 * Fast interrupt pending latches and the registered 32-bit interrupt vector.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module irq_vector_map
  import irq_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       irq_software_i,
  input  logic       irq_external_i,
  input  timer_irq_t timer_irq_i,
  input  fast_src_t  fast_src_i,
  input  fast_irq_t  fast_clr_i,
  output irq_vec_t   intr_o
);

  fast_irq_t fast_raw;
  fast_irq_t pending_q, pending_d;
  irq_vec_t  intr_q, intr_d;

  // top bit of the fast group stays reserved
  assign fast_raw = {1'b0,
                     fast_src_i.gpio_ao,
                     fast_src_i.spi_flash,
                     fast_src_i.spi,
                     fast_src_i.dma_done,
                     fast_src_i.timer | timer_irq_i[3:1]};

  // set wins over a same-cycle clear
  assign pending_d = (pending_q & ~fast_clr_i) | fast_raw;

  always_comb begin
    intr_d                               = '0;
    intr_d[`IRQ_SW_POS]                  = irq_software_i;
    intr_d[`IRQ_TIMER0_POS]              = timer_irq_i[0];
    intr_d[`IRQ_EXT_POS]                 = irq_external_i;
    intr_d[`IRQ_FAST_HI:`IRQ_FAST_LO]    = pending_d;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      intr_q    <= '0;
    end else begin
      pending_q <= pending_d;
      intr_q    <= intr_d;
    end
  end

  assign intr_o = intr_q;

endmodule

`default_nettype wire

/* hw/pwr_sequencer.sv */
/*
 * Power sequencer FSM. Runs ON, OFF and retention step lists on one domain
 * and powers the CPU domain back up when an interrupt is pending.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module pwr_sequencer
  import pwr_pkg::*;
  import irq_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    cmd_valid_i,
  input  pwr_cmd_t                cmd_i,
  input  irq_vec_t                intr_i,
  input  logic [`NUM_DOMAINS-1:0] ack_n_sync_i,
  input  logic                    cpu_pwr_on_i,
  input  logic                    tmr_done_i,
  input  logic                    tmr_expired_i,
  output logic                    tmr_start_o,
  output logic                    tmr_mode_o,
  output logic                    tmr_stop_o,
  output logic                    step_we_o,
  output domain_idx_t             step_dom_o,
  output pwr_step_e               step_kind_o,
  output logic                    step_val_o,
  output logic                    busy_o,
  output logic                    err_o
);

  seq_state_e state_q, state_d;
  pwr_cmd_t   cmd_q;
  logic [2:0] idx_q;
  logic       idx_inc;
  logic       err_q, err_d;
  logic       wakeup;
  logic       is_bank;
  logic       cmd_bad;
  logic       needs_ack;
  logic       is_last;
  logic       ack_ok;

  assign wakeup  = ~cpu_pwr_on_i & (|intr_i);
  assign is_bank = (cmd_q.dom >= `BANK0_DOM) && (cmd_q.dom < `BANK0_DOM + `NUM_BANKS);
  assign cmd_bad = ((cmd_q.op == PWR_RET) && !is_bank) ||
                   !(cmd_q.op inside {PWR_ON, PWR_OFF, PWR_RET});

  // switch ack_n follows the pwrgate level that was just written
  assign ack_ok  = (ack_n_sync_i[cmd_q.dom] == step_val_o);

  assign step_dom_o = cmd_q.dom;
  assign step_val_o = (cmd_q.op == PWR_ON);
  assign busy_o     = (state_q != SEQ_IDLE);
  assign err_o      = err_q;

  // step list per operation
  always_comb begin
    step_kind_o = STEP_CLKGATE;
    needs_ack   = 1'b0;
    is_last     = 1'b0;
    case (cmd_q.op)
      PWR_OFF: begin
        case (idx_q)
          3'd0: step_kind_o = STEP_CLKGATE;
          3'd1: step_kind_o = STEP_ISOGATE;
          3'd2: step_kind_o = STEP_RST;
          default: begin
            step_kind_o = STEP_PWRGATE;
            needs_ack   = 1'b1;
            is_last     = 1'b1;
          end
        endcase
      end
      PWR_ON: begin
        case (idx_q)
          3'd0: step_kind_o = STEP_RETENTIVE;
          3'd1: begin
            step_kind_o = STEP_PWRGATE;
            needs_ack   = 1'b1;
          end
          3'd2: step_kind_o = STEP_RST;
          3'd3: step_kind_o = STEP_ISOGATE;
          default: begin
            step_kind_o = STEP_CLKGATE;
            is_last     = 1'b1;
          end
        endcase
      end
      default: begin
        // retention keeps the switch on
        if (idx_q == 3'd0) begin
          step_kind_o = STEP_CLKGATE;
        end else begin
          step_kind_o = STEP_RETENTIVE;
          is_last     = 1'b1;
        end
      end
    endcase
  end

  always_comb begin
    state_d     = state_q;
    step_we_o   = 1'b0;
    tmr_start_o = 1'b0;
    tmr_mode_o  = 1'b0;
    tmr_stop_o  = 1'b0;
    idx_inc     = 1'b0;
    err_d       = 1'b0;
    case (state_q)
      SEQ_IDLE: begin
        if (wakeup || cmd_valid_i) begin
          state_d = SEQ_STEP;
        end
      end
      SEQ_STEP: begin
        if (cmd_bad) begin
          err_d   = 1'b1;
          state_d = SEQ_IDLE;
        end else begin
          step_we_o   = 1'b1;
          tmr_start_o = 1'b1;
          state_d     = SEQ_SETTLE;
        end
      end
      SEQ_SETTLE: begin
        if (tmr_done_i) begin
          if (needs_ack) begin
            tmr_start_o = 1'b1;
            tmr_mode_o  = 1'b1;
            state_d     = SEQ_ACK_WAIT;
          end else if (is_last) begin
            state_d = SEQ_IDLE;
          end else begin
            idx_inc = 1'b1;
            state_d = SEQ_STEP;
          end
        end
      end
      SEQ_ACK_WAIT: begin
        if (ack_ok) begin
          tmr_stop_o = 1'b1;
          if (is_last) begin
            state_d = SEQ_IDLE;
          end else begin
            idx_inc = 1'b1;
            state_d = SEQ_STEP;
          end
        end else if (tmr_expired_i) begin
          // switch is left as driven
          err_d   = 1'b1;
          state_d = SEQ_IDLE;
        end
      end
      default: state_d = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= SEQ_IDLE;
      idx_q   <= '0;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
      if (state_q == SEQ_IDLE) begin
        idx_q <= '0;
      end else if (idx_inc) begin
        idx_q <= idx_q + 3'd1;
      end
    end
  end

  // wakeup wins over a same-cycle strobe
  always_ff @(posedge clk_i) begin
    if (state_q == SEQ_IDLE) begin
      if (wakeup) begin
        cmd_q.dom <= domain_idx_t'(`CPU_DOM);
        cmd_q.op  <= PWR_ON;
      end else if (cmd_valid_i) begin
        cmd_q <= cmd_i;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/mcu_pwr_top.sv */
/*
 * Always-on power and interrupt block of the MCU.
 * Sequencer, domain registers, step timer and interrupt vector.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module mcu_pwr_top
  import pwr_pkg::*;
  import irq_pkg::*;
(
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         cmd_valid_i,
  input  pwr_cmd_t                     cmd_i,
  output logic                         busy_o,
  output logic                         err_o,
  output pwr_ctrl_t [`NUM_DOMAINS-1:0] pwr_ctrl_o,
  input  logic [`NUM_DOMAINS-1:0]      pwrgate_ack_ni,
  input  logic                         ndmreset_ni,
  input  logic                         irq_software_i,
  input  logic                         irq_external_i,
  input  timer_irq_t                   timer_irq_i,
  input  fast_src_t                    fast_src_i,
  input  fast_irq_t                    fast_clr_i,
  output irq_vec_t                     intr_o
);

  logic [`NUM_DOMAINS-1:0] ack_n_sync;
  logic                    cpu_pwr_on;
  logic                    tmr_start;
  logic                    tmr_mode;
  logic                    tmr_stop;
  logic                    tmr_done;
  logic                    tmr_expired;
  logic                    step_we;
  domain_idx_t             step_dom;
  pwr_step_e               step_kind;
  logic                    step_val;

  pwr_sequencer pwr_sequencer_i (
    .clk_i,
    .rst_n_i,
    .cmd_valid_i,
    .cmd_i,
    .intr_i        (intr_o),
    .ack_n_sync_i  (ack_n_sync),
    .cpu_pwr_on_i  (cpu_pwr_on),
    .tmr_done_i    (tmr_done),
    .tmr_expired_i (tmr_expired),
    .tmr_start_o   (tmr_start),
    .tmr_mode_o    (tmr_mode),
    .tmr_stop_o    (tmr_stop),
    .step_we_o     (step_we),
    .step_dom_o    (step_dom),
    .step_kind_o   (step_kind),
    .step_val_o    (step_val),
    .busy_o,
    .err_o
  );

  pwr_domain_regs pwr_domain_regs_i (
    .clk_i,
    .rst_n_i,
    .step_we_i    (step_we),
    .step_dom_i   (step_dom),
    .step_kind_i  (step_kind),
    .step_val_i   (step_val),
    .ndmreset_ni,
    .pwrgate_ack_ni,
    .ack_n_sync_o (ack_n_sync),
    .cpu_pwr_on_o (cpu_pwr_on),
    .pwr_ctrl_o
  );

  pwr_step_timer pwr_step_timer_i (
    .clk_i,
    .rst_n_i,
    .start_i   (tmr_start),
    .mode_i    (tmr_mode),
    .stop_i    (tmr_stop),
    .done_o    (tmr_done),
    .expired_o (tmr_expired)
  );

  irq_vector_map irq_vector_map_i (
    .clk_i,
    .rst_n_i,
    .irq_software_i,
    .irq_external_i,
    .timer_irq_i,
    .fast_src_i,
    .fast_clr_i,
    .intr_o
  );

endmodule

`default_nettype wire

/* verif/mcu_pwr_tb.sv */
/*
 * Testbench for the MCU power and interrupt block. Models the switch cells,
 * predicts domain controls and the interrupt vector, and compares them.
 */
`timescale 1ns/1ps
`default_nettype none
`include "mcu_consts.svh"

module mcu_pwr_tb
  import pwr_pkg::*;
  import irq_pkg::*;
;

  localparam int CLK_HALF      = 10;
  localparam int NUM_RAND_CMDS = 20;
  localparam int CMD_CYCLES    = `ACK_TIMEOUT + 10 * `STEP_DELAY + 20;
  localparam int TOTAL_CMDS    = NUM_RAND_CMDS + 17;
  localparam int WDOG_CYCLES   = TOTAL_CMDS * CMD_CYCLES + 500;

  logic                         clk_i;
  logic                         rst_n_i;
  logic                         cmd_valid_i;
  pwr_cmd_t                     cmd_i;
  logic                         busy_o;
  logic                         err_o;
  pwr_ctrl_t [`NUM_DOMAINS-1:0] pwr_ctrl_o;
  logic [`NUM_DOMAINS-1:0]      pwrgate_ack_ni;
  logic                         ndmreset_ni;
  logic                         irq_software_i;
  logic                         irq_external_i;
  timer_irq_t                   timer_irq_i;
  fast_src_t                    fast_src_i;
  fast_irq_t                    fast_clr_i;
  irq_vec_t                     intr_o;

  integer                  seed     = 32'h86baaf8d;
  integer                  ack_seed = 32'h86baaf8d;
  logic [`NUM_DOMAINS-1:0] stuck;
  int                      ack_dly [`NUM_DOMAINS];

  // reference model state
  pwr_ctrl_t model_ctrl [`NUM_DOMAINS];
  fast_irq_t model_pend;
  logic      model_sw;
  logic      model_ext;
  logic      model_t0;

  // comparator handshake
  pwr_ctrl_t   exp_ctrl_arr [`NUM_DOMAINS];
  irq_vec_t    exp_intr;
  string       chk_name;
  int          chk_req_cnt  = 0;
  int          chk_done_cnt = 0;
  int          cmp_errors   = 0;
  int          errors       = 0;

  // monitor state
  domain_idx_t mon_dom    = '0;
  pwr_ctrl_t   mon_prev [`NUM_DOMAINS];
  int          fall_q[$];
  int          err_pulses = 0;

  mcu_pwr_top uut (
    .clk_i,
    .rst_n_i,
    .cmd_valid_i,
    .cmd_i,
    .busy_o,
    .err_o,
    .pwr_ctrl_o,
    .pwrgate_ack_ni,
    .ndmreset_ni,
    .irq_software_i,
    .irq_external_i,
    .timer_irq_i,
    .fast_src_i,
    .fast_clr_i,
    .intr_o
  );

  initial begin
    clk_i = 1'b0;
    forever #CLK_HALF clk_i = ~clk_i;
  end

  function automatic logic is_bank(input domain_idx_t dom);
    return (dom >= domain_idx_t'(`BANK0_DOM)) &&
           (dom < domain_idx_t'(`BANK0_DOM + `NUM_BANKS));
  endfunction

  function automatic pwr_ctrl_t expected_ctrl(input pwr_ctrl_t prev, input pwr_op_e op,
                                              input domain_idx_t dom);
    pwr_ctrl_t r;
    r = prev;
    case (op)
      PWR_OFF: begin
        r.clkgate_en_n = 1'b0;
        r.isogate_en_n = 1'b0;
        r.rst_n        = 1'b0;
        r.pwrgate_en_n = 1'b0;
      end
      PWR_ON: r = '1;
      default: begin
        // only banks may retain
        if (is_bank(dom)) begin
          r.clkgate_en_n   = 1'b0;
          r.retentive_en_n = 1'b0;
        end
      end
    endcase
    return r;
  endfunction

  function automatic irq_vec_t expected_intr(input fast_irq_t pend, input logic sw,
                                             input logic ext, input logic t0);
    irq_vec_t v;
    v                              = '0;
    v[`IRQ_SW_POS]                 = sw;
    v[`IRQ_TIMER0_POS]             = t0;
    v[`IRQ_EXT_POS]                = ext;
    v[`IRQ_FAST_HI:`IRQ_FAST_LO]   = pend;
    return v;
  endfunction

  // expected falling order packed as nibbles (clk 1 iso 2 rst 3 pwr 4)
  function automatic int off_order(input pwr_ctrl_t prev);
    int code;
    code = 0;
    if (prev.clkgate_en_n) code = code * 16 + 1;
    if (prev.isogate_en_n) code = code * 16 + 2;
    if (prev.rst_n) code = code * 16 + 3;
    if (prev.pwrgate_en_n) code = code * 16 + 4;
    return code;
  endfunction

  // switch cells drive ack_n to pwrgate_en_n after 1 to 10 cycles
  initial begin
    pwrgate_ack_ni = '1;
    for (int d = 0; d < `NUM_DOMAINS; d++) ack_dly[d] = 0;
    forever begin
      @(posedge clk_i);
      for (int d = 0; d < `NUM_DOMAINS; d++) begin
        if (!rst_n_i || stuck[d]) begin
          ack_dly[d] = 0;
          if (!rst_n_i) pwrgate_ack_ni[d] <= 1'b1;
        end else if (pwrgate_ack_ni[d] != pwr_ctrl_o[d].pwrgate_en_n) begin
          if (ack_dly[d] == 0) ack_dly[d] = 1 + int'($unsigned($random(ack_seed)) % 10);
          if (ack_dly[d] == 1) begin
            pwrgate_ack_ni[d] <= pwr_ctrl_o[d].pwrgate_en_n;
            ack_dly[d] = 0;
          end else begin
            ack_dly[d]--;
          end
        end else begin
          ack_dly[d] = 0;
        end
      end
    end
  end

  // err pulses and falling controls of the watched domain
  initial begin
    for (int d = 0; d < `NUM_DOMAINS; d++) mon_prev[d] = '1;
    forever begin
      @(negedge clk_i);
      if (err_o === 1'b1) err_pulses++;
      if (mon_prev[mon_dom].clkgate_en_n && !pwr_ctrl_o[mon_dom].clkgate_en_n) begin
        fall_q.push_back(1);
      end
      if (mon_prev[mon_dom].isogate_en_n && !pwr_ctrl_o[mon_dom].isogate_en_n) begin
        fall_q.push_back(2);
      end
      if (mon_prev[mon_dom].rst_n && !pwr_ctrl_o[mon_dom].rst_n) begin
        fall_q.push_back(3);
      end
      if (mon_prev[mon_dom].pwrgate_en_n && !pwr_ctrl_o[mon_dom].pwrgate_en_n) begin
        fall_q.push_back(4);
      end
      for (int d = 0; d < `NUM_DOMAINS; d++) mon_prev[d] = pwr_ctrl_o[d];
    end
  end

  // comparator
  initial begin
    forever begin
      @(negedge clk_i);
      if (chk_done_cnt != chk_req_cnt) begin
        for (int d = 0; d < `NUM_DOMAINS; d++) begin
          if (pwr_ctrl_o[d] !== exp_ctrl_arr[d]) begin
            cmp_errors++;
            $display("CHECK FAILED %s pwr_ctrl dom%0d: expected %b, actual %b",
                     chk_name, d, exp_ctrl_arr[d], pwr_ctrl_o[d]);
          end
        end
        if (intr_o !== exp_intr) begin
          cmp_errors++;
          $display("CHECK FAILED %s intr: expected %h, actual %h", chk_name, exp_intr, intr_o);
        end
        chk_done_cnt = chk_req_cnt;
      end
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, the run did not finish", WDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  task automatic request_check(input string name, input logic ndm_low);
    for (int d = 0; d < `NUM_DOMAINS; d++) begin
      exp_ctrl_arr[d] = model_ctrl[d];
      if (ndm_low) exp_ctrl_arr[d].rst_n = 1'b0;
    end
    exp_intr = expected_intr(model_pend, model_sw, model_ext, model_t0);
    chk_name = name;
    chk_req_cnt++;
    wait (chk_done_cnt == chk_req_cnt);
  endtask

  task automatic wait_idle(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (busy_o && n < CMD_CYCLES) begin
      @(negedge clk_i);
      n++;
    end
    if (busy_o) begin
      errors++;
      $display("%s: busy_o stayed high for more than %0d cycles", name, CMD_CYCLES);
    end
  endtask

  task automatic wait_busy(input string name);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!busy_o && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (!busy_o) begin
      errors++;
      $display("%s: no sequence started", name);
    end
  endtask

  task automatic run_cmd(input string name, input domain_idx_t dom, input pwr_op_e op,
                         input logic drop, input int exp_err);
    pwr_ctrl_t prev;
    int        err_base;
    int        fall_base;
    int        order;
    prev = model_ctrl[dom];
    @(posedge clk_i);
    err_base    = err_pulses;
    fall_base   = fall_q.size();
    mon_dom     = dom;
    cmd_valid_i <= 1'b1;
    cmd_i       <= '{dom: dom, op: op};
    @(posedge clk_i);
    cmd_valid_i <= 1'b0;
    @(negedge clk_i);
    if (!busy_o) begin
      errors++;
      $display("%s: busy_o did not rise after the command strobe", name);
    end
    // a second strobe while busy must be dropped
    if (drop) begin
      @(posedge clk_i);
      cmd_valid_i <= 1'b1;
      cmd_i       <= '{dom: dom + 3'd1, op: (op == PWR_ON) ? PWR_OFF : PWR_ON};
      @(posedge clk_i);
      cmd_valid_i <= 1'b0;
    end
    wait_idle(name);
    @(posedge clk_i);
    if (err_pulses - err_base != exp_err) begin
      errors++;
      $display("CHECK FAILED %s err pulses: expected %0d, actual %0d",
               name, exp_err, err_pulses - err_base);
    end
    if (op == PWR_OFF) begin
      order = 0;
      for (int i = fall_base; i < fall_q.size(); i++) order = order * 16 + fall_q[i];
      if (order != off_order(prev)) begin
        errors++;
        $display("CHECK FAILED %s off order: expected %h, actual %h",
                 name, off_order(prev), order);
      end
    end
    model_ctrl[dom] = expected_ctrl(prev, op, dom);
    request_check(name, 1'b0);
  endtask

  initial begin
    domain_idx_t dom;
    pwr_op_e     op;
    logic        drop;
    int          idx;
    rst_n_i        <= 1'b0;
    cmd_valid_i    <= 1'b0;
    cmd_i          <= '0;
    ndmreset_ni    <= 1'b1;
    irq_software_i <= 1'b0;
    irq_external_i <= 1'b0;
    timer_irq_i    <= '0;
    fast_src_i     <= '0;
    fast_clr_i     <= '0;
    stuck          <= '0;
    for (int d = 0; d < `NUM_DOMAINS; d++) model_ctrl[d] = '1;
    model_pend = '0;
    model_sw   = 1'b0;
    model_ext  = 1'b0;
    model_t0   = 1'b0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;

    @(posedge clk_i);
    request_check("reset", 1'b0);
    if (busy_o !== 1'b0 || err_o !== 1'b0) begin
      errors++;
      $display("CHECK FAILED reset busy/err: expected 00, actual %b%b", busy_o, err_o);
    end

    for (int i = 0; i < NUM_RAND_CMDS; i++) begin
      dom  = domain_idx_t'($unsigned($random(seed)) % `NUM_DOMAINS);
      op   = ($random(seed) & 1) ? PWR_ON : PWR_OFF;
      drop = ($random(seed) & 1) ? 1'b1 : 1'b0;
      run_cmd($sformatf("rand%0d", i), dom, op, drop, 0);
    end

    // retention is legal for banks only
    for (int d = 0; d < `NUM_DOMAINS; d++) begin
      if (is_bank(domain_idx_t'(d))) begin
        run_cmd($sformatf("ret_prep%0d", d), domain_idx_t'(d), PWR_ON, 1'b0, 0);
      end
      run_cmd($sformatf("ret_dom%0d", d), domain_idx_t'(d), PWR_RET, 1'b0,
              is_bank(domain_idx_t'(d)) ? 0 : 1);
    end

    // stuck switch ack on an external domain
    run_cmd("stuck_prep", domain_idx_t'(`EXT0_DOM), PWR_ON, 1'b0, 0);
    @(posedge clk_i);
    stuck[`EXT0_DOM] <= 1'b1;
    run_cmd("stuck_off", domain_idx_t'(`EXT0_DOM), PWR_OFF, 1'b0, 1);
    @(posedge clk_i);
    stuck[`EXT0_DOM] <= 1'b0;
    repeat (20) @(posedge clk_i);
    run_cmd("stuck_recover", domain_idx_t'(`EXT0_DOM), PWR_ON, 1'b0, 0);

    // interrupt wakeup of the cpu domain
    run_cmd("cpu_off", domain_idx_t'(`CPU_DOM), PWR_OFF, 1'b0, 0);
    idx = int'($unsigned($random(seed)) % 14);
    @(posedge clk_i);
    fast_src_i <= fast_src_t'(15'(1) << idx);
    @(posedge clk_i);
    fast_src_i <= '0;
    model_pend[idx] = 1'b1;
    request_check("fast_pending", 1'b0);
    wait_busy("wakeup");
    wait_idle("wakeup");
    @(posedge clk_i);
    model_ctrl[`CPU_DOM] = expected_ctrl(model_ctrl[`CPU_DOM], PWR_ON, domain_idx_t'(`CPU_DOM));
    request_check("wakeup_on", 1'b0);
    @(posedge clk_i);
    fast_clr_i <= fast_irq_t'(15'(1) << idx);
    @(posedge clk_i);
    fast_clr_i <= '0;
    model_pend[idx] = 1'b0;
    request_check("fast_clear", 1'b0);

    @(posedge clk_i);
    irq_software_i <= 1'b1;
    irq_external_i <= 1'b1;
    timer_irq_i    <= 4'b0001;
    @(posedge clk_i);
    irq_software_i <= 1'b0;
    irq_external_i <= 1'b0;
    timer_irq_i    <= '0;
    model_sw  = 1'b1;
    model_ext = 1'b1;
    model_t0  = 1'b1;
    request_check("irq_lines", 1'b0);
    @(posedge clk_i);
    model_sw  = 1'b0;
    model_ext = 1'b0;
    model_t0  = 1'b0;
    request_check("irq_lines_low", 1'b0);

    // debug reset pulls every domain reset low
    @(posedge clk_i);
    ndmreset_ni <= 1'b0;
    request_check("ndmreset_low", 1'b1);
    repeat (3) @(posedge clk_i);
    ndmreset_ni <= 1'b1;
    request_check("ndmreset_release", 1'b0);

    repeat (2) @(posedge clk_i);
    $display("errors: sequence checks %0d, comparator %0d", errors, cmp_errors);
    if (errors == 0 && cmp_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mcu_pwr.f */
+incdir+hw
hw/pwr_pkg.sv
hw/irq_pkg.sv
hw/pwr_step_timer.sv
hw/pwr_domain_regs.sv
hw/irq_vector_map.sv
hw/pwr_sequencer.sv
hw/mcu_pwr_top.sv
verif/mcu_pwr_tb.sv

/* Makefile */
# Verilator flow for the mcu_pwr block

VERILATOR ?= verilator
FILELIST  ?= mcu_pwr.f
TB_TOP    ?= mcu_pwr_tb
RTL_TOP   ?= mcu_pwr_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
FAIL_MSG  ?= Simulation failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(wildcard hw/*.sv hw/*.svh verif/*.sv)
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) \
	  --top-module $(TB_TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	  if grep -q "$(FAIL_MSG)" $(LOG); then \
	    echo "simulation reported failure, see $(LOG)"; exit 1; \
	  fi; \
	  if [ $$status -ne 0 ]; then \
	    echo "simulator exited with status $$status"; exit 1; \
	  fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
